// File: all.f
mps_pkg.sv
mps_intl_latch.sv
mps_on_seq.sv
mps_off_seq.sv
mps_system_fsm.sv
mps_top.sv
tb_mps_top.sv

// File: mps_intl_latch.sv
`timescale 1ns/1ps
`default_nettype none

module mps_intl_latch
(
	input  wire                 i_clk,
	input  wire                 i_rst,
	input  wire mps_pkg::mps_fault_t i_fault,
	input  wire                 i_intl_clr,
	output logic                o_intl_flag,
	output mps_pkg::mps_fault_t o_faults
);
	import mps_pkg::*;

	mps_fault_t clr_mask;

	// A clear strobe only releases bits whose cause has gone away.
	assign clr_mask = i_intl_clr ? mps_fault_t'(~i_fault) : FAULT_NONE;

	// Even a one-cycle glitch on a fault input is held here.
	always_ff @(posedge i_clk or negedge i_rst)
	begin
		if (!i_rst)
			o_faults <= FAULT_NONE;
		else
			o_faults <= (o_faults & ~clr_mask) | i_fault;
	end

	assign o_intl_flag = |o_faults;

	a_flag_with_faults: assert property (
		@(posedge i_clk) disable iff (!i_rst)
		(o_faults != FAULT_NONE) |-> o_intl_flag
	) else $error("interlock flag low with latched faults");

endmodule

`default_nettype wire

// File: mps_off_seq.sv
`timescale 1ns/1ps
`default_nettype none

module mps_off_seq
#(
	parameter int unsigned STEP_CYCLES = 16
)
(
	input  wire                    i_clk,
	input  wire                    i_rst,
	input  wire                    i_start,
	input  wire                    i_intl,
	output mps_pkg::mps_off_step_e o_step
);
	import mps_pkg::*;

	localparam int unsigned DW = (STEP_CYCLES > 1) ? $clog2(STEP_CYCLES) : 1;

	mps_off_step_e step_nxt;
	logic [DW-1:0] dwell_cnt;
	logic          dwell_done;

	assign dwell_done = (dwell_cnt == DW'(STEP_CYCLES - 1));

	// Main opens first so the link is never discharged under load.
	always_comb
	begin
		step_nxt = o_step;
		if (i_intl)
			step_nxt = OFF_IDLE;
		else
		begin
			case (o_step)
				OFF_IDLE      : if (i_start) step_nxt = OFF_MAIN_OPEN;
				OFF_MAIN_OPEN : if (dwell_done) step_nxt = OFF_DISCH;
				OFF_DISCH     : if (dwell_done) step_nxt = OFF_DONE;
				default       : step_nxt = OFF_IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clk or negedge i_rst)
	begin
		if (!i_rst)
		begin
			o_step    <= OFF_IDLE;
			dwell_cnt <= '0;
		end
		else
		begin
			o_step <= step_nxt;
			if (step_nxt != o_step)
				dwell_cnt <= '0;
			else if (!dwell_done)
				dwell_cnt <= dwell_cnt + 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: mps_on_seq.sv
`timescale 1ns/1ps
`default_nettype none

module mps_on_seq
#(
	parameter int unsigned STEP_CYCLES    = 16,
	parameter int unsigned CHARGE_TIMEOUT = 64
)
(
	input  wire                   i_clk,
	input  wire                   i_rst,
	input  wire                   i_start,
	input  wire                   i_intl,
	input  wire                   i_dc_link_ok,
	output mps_pkg::mps_on_step_e o_step
);
	import mps_pkg::*;

	localparam int unsigned DW = (STEP_CYCLES > 1) ? $clog2(STEP_CYCLES) : 1;
	localparam int unsigned CW = (CHARGE_TIMEOUT > 1) ? $clog2(CHARGE_TIMEOUT) : 1;

	mps_on_step_e step_nxt;
	logic [DW-1:0] dwell_cnt;
	logic [CW-1:0] charge_cnt;
	logic          dwell_done;
	logic          charge_expired;
	logic          link_seen;
	logic          charged;

	assign dwell_done     = (dwell_cnt == DW'(STEP_CYCLES - 1));
	assign charge_expired = (charge_cnt == CW'(CHARGE_TIMEOUT - 1));
	assign charged        = link_seen | i_dc_link_ok;

	always_comb
	begin
		step_nxt = o_step;
		if (i_intl)
			step_nxt = ON_IDLE;
		else
		begin
			case (o_step)
				ON_IDLE     : if (i_start) step_nxt = ON_DISCH;
				ON_DISCH    : if (dwell_done) step_nxt = ON_SLOW;
				ON_SLOW     :
				begin
					// A late charge still wins over the timeout in the same cycle.
					if (dwell_done && charged)
						step_nxt = ON_MAIN;
					else if (charge_expired)
						step_nxt = ON_ABORT;
				end
				ON_MAIN     : if (dwell_done) step_nxt = ON_SLOW_OFF;
				ON_SLOW_OFF : if (dwell_done) step_nxt = ON_DONE;
				default     : step_nxt = ON_IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clk or negedge i_rst)
	begin
		if (!i_rst)
		begin
			o_step    <= ON_IDLE;
			dwell_cnt <= '0;
		end
		else
		begin
			o_step <= step_nxt;
			// The dwell restarts on every step change and saturates otherwise.
			if (step_nxt != o_step)
				dwell_cnt <= '0;
			else if (!dwell_done)
				dwell_cnt <= dwell_cnt + 1'b1;
		end
	end

	always_ff @(posedge i_clk or negedge i_rst)
	begin
		if (!i_rst)
		begin
			charge_cnt <= '0;
			link_seen  <= 1'b0;
		end
		else if (o_step != ON_SLOW)
		begin
			charge_cnt <= '0;
			link_seen  <= 1'b0;
		end
		else
		begin
			if (!charge_expired)
				charge_cnt <= charge_cnt + 1'b1;
			if (i_dc_link_ok)
				link_seen <= 1'b1;
		end
	end

	// The main contactor may only close after the slow-charge step.
	a_main_after_slow: assert property (
		@(posedge i_clk) disable iff (!i_rst)
		((o_step == ON_MAIN) && ($past(o_step) != ON_MAIN)) |-> ($past(o_step) == ON_SLOW)
	) else $error("ON_MAIN entered from a step other than ON_SLOW");

endmodule

`default_nettype wire

// File: mps_pkg.sv
`default_nettype none

package mps_pkg;

	// System states of the supervisory controller.
	typedef enum logic [2:0] {
		IDLE        = 3'd0,
		OP_ON       = 3'd1,
		OP_ON_HOLD  = 3'd2,
		READY       = 3'd3,
		RUN         = 3'd4,
		OP_OFF      = 3'd5,
		OP_OFF_HOLD = 3'd6,
		INTL        = 3'd7
	} mps_state_e;

	// Power-on step codes, with gaps in the numbering.
	typedef enum logic [3:0] {
		ON_IDLE     = 4'd0,
		ON_DISCH    = 4'd1,
		ON_SLOW     = 4'd5,
		ON_MAIN     = 4'd9,
		ON_SLOW_OFF = 4'd11,
		ON_DONE     = 4'd14,
		ON_ABORT    = 4'd15
	} mps_on_step_e;

	typedef enum logic [3:0] {
		OFF_IDLE      = 4'd0,
		OFF_MAIN_OPEN = 4'd1,
		OFF_DISCH     = 4'd2,
		OFF_DONE      = 4'd3
	} mps_off_step_e;

	// Operator commands, each a single-cycle strobe.
	typedef struct packed {
		logic op_on;
		logic op_off;
		logic run;
		logic ready;
	} mps_cmd_t;

	typedef struct packed {
		logic overcurrent;
		logic overvoltage;
		logic overtemp;
		logic external;
	} mps_fault_t;

	// The discharge contactor is closed when its drive is low.
	typedef struct packed {
		logic discharge_n;
		logic slow;
		logic main;
	} mps_mc_t;

	typedef struct packed {
		mps_state_e    state;
		mps_on_step_e  on_step;
		mps_off_step_e off_step;
		mps_fault_t    faults;
	} mps_status_t;

	// All contactor coils de-energized.
	localparam mps_mc_t MC_OPEN = '{default: 1'b0};

	localparam mps_fault_t FAULT_NONE = '{default: 1'b0};

endpackage

`default_nettype wire

// File: mps_system_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module mps_system_fsm
(
	input  wire                    i_clk,
	input  wire                    i_rst,
	input  wire mps_pkg::mps_cmd_t i_cmd,
	input  wire                    i_intl_flag,
	input  wire mps_pkg::mps_on_step_e  i_on_step,
	input  wire mps_pkg::mps_off_step_e i_off_step,
	output logic                   o_on_start,
	output logic                   o_off_start,
	output mps_pkg::mps_mc_t       o_mc,
	output logic                   o_pwm_en,
	output logic                   o_fsm_intl,
	output mps_pkg::mps_state_e    o_state
);
	import mps_pkg::*;

	mps_state_e state_q;
	mps_state_e state_nxt;

	// The interlock overrides the table, so INTL repeats while the flag is up.
	always_ff @(posedge i_clk or negedge i_rst)
	begin
		if (!i_rst)
			state_q <= IDLE;
		else if (i_intl_flag)
			state_q <= INTL;
		else
			state_q <= state_nxt;
	end

	always_comb
	begin
		state_nxt = state_q;
		case (state_q)
			IDLE        : if (i_cmd.op_on) state_nxt = OP_ON;
			OP_ON       : state_nxt = OP_ON_HOLD;
			OP_ON_HOLD  :
			begin
				if (i_on_step == ON_ABORT)
					state_nxt = IDLE;
				else if (i_on_step == ON_DONE)
					state_nxt = READY;
			end
			READY       :
			begin
				if (i_cmd.run)
					state_nxt = RUN;
				else if (i_cmd.op_off)
					state_nxt = OP_OFF;
			end
			RUN         : if (i_cmd.ready) state_nxt = READY;
			OP_OFF      : state_nxt = OP_OFF_HOLD;
			OP_OFF_HOLD : if (i_off_step == OFF_DONE) state_nxt = IDLE;
			default     : state_nxt = IDLE;
		endcase
	end

	// Start pulses follow one cycle after OP_ON or OP_OFF.
	always_ff @(posedge i_clk or negedge i_rst)
	begin
		if (!i_rst)
		begin
			o_on_start  <= 1'b0;
			o_off_start <= 1'b0;
		end
		else
		begin
			o_on_start  <= (state_q == OP_ON);
			o_off_start <= (state_q == OP_OFF);
		end
	end

	// Contactors open at the same edge on which the state enters INTL.
	always_ff @(posedge i_clk or negedge i_rst)
	begin
		if (!i_rst)
			o_mc <= MC_OPEN;
		else if (i_intl_flag || (state_q == INTL))
			o_mc <= MC_OPEN;
		else if (state_q == OP_ON_HOLD)
		begin
			case (i_on_step)
				ON_IDLE     : o_mc <= MC_OPEN;
				ON_DISCH    : o_mc <= '{discharge_n: 1'b1, slow: 1'b0, main: 1'b0};
				ON_SLOW     : o_mc <= '{discharge_n: 1'b1, slow: 1'b1, main: 1'b0};
				ON_MAIN     : o_mc <= '{discharge_n: 1'b1, slow: 1'b1, main: 1'b1};
				ON_SLOW_OFF : o_mc <= '{discharge_n: 1'b1, slow: 1'b0, main: 1'b1};
				ON_ABORT    : o_mc <= MC_OPEN;
				default     : o_mc <= o_mc;
			endcase
		end
		else if (state_q == OP_OFF_HOLD)
		begin
			case (i_off_step)
				OFF_MAIN_OPEN : o_mc <= '{discharge_n: 1'b1, slow: 1'b0, main: 1'b0};
				OFF_DISCH     : o_mc <= MC_OPEN;
				default       : o_mc <= o_mc;
			endcase
		end
	end

	assign o_pwm_en   = (state_q == RUN);
	assign o_fsm_intl = (state_q == INTL);
	assign o_state    = state_q;

	// The bridge may only switch with the main contactor closed.
	a_pwm_needs_main: assert property (
		@(posedge i_clk) disable iff (!i_rst)
		o_pwm_en |-> o_mc.main
	) else $error("PWM enabled with main contactor open");

	a_intl_open: assert property (
		@(posedge i_clk) disable iff (!i_rst)
		(state_q == INTL) |-> (o_mc == MC_OPEN)
	) else $error("contactors not open in INTL");

endmodule

`default_nettype wire

// File: mps_top.sv
`timescale 1ns/1ps
`default_nettype none

module mps_top
#(
	parameter int unsigned STEP_CYCLES    = 16,
	parameter int unsigned CHARGE_TIMEOUT = 64
)
(
	input  wire                      i_clk,
	input  wire                      i_rst,
	input  wire mps_pkg::mps_cmd_t   i_cmd,
	input  wire mps_pkg::mps_fault_t i_fault,
	input  wire                      i_intl_clr,
	input  wire                      i_dc_link_ok,
	output mps_pkg::mps_mc_t         o_mc,
	output logic                     o_pwm_en,
	output logic                     o_fsm_intl,
	output mps_pkg::mps_status_t     o_status
);
	import mps_pkg::*;

	logic          intl_flag;
	logic          on_start;
	logic          off_start;
	mps_on_step_e  on_step;
	mps_off_step_e off_step;
	mps_state_e    state;
	mps_fault_t    faults;

	mps_intl_latch u_intl_latch (
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.i_fault     (i_fault),
		.i_intl_clr  (i_intl_clr),
		.o_intl_flag (intl_flag),
		.o_faults    (faults)
	);

	mps_on_seq #(
		.STEP_CYCLES    (STEP_CYCLES),
		.CHARGE_TIMEOUT (CHARGE_TIMEOUT)
	) u_on_seq (
		.i_clk        (i_clk),
		.i_rst        (i_rst),
		.i_start      (on_start),
		.i_intl       (intl_flag),
		.i_dc_link_ok (i_dc_link_ok),
		.o_step       (on_step)
	);

	mps_off_seq #(
		.STEP_CYCLES (STEP_CYCLES)
	) u_off_seq (
		.i_clk   (i_clk),
		.i_rst   (i_rst),
		.i_start (off_start),
		.i_intl  (intl_flag),
		.o_step  (off_step)
	);

	mps_system_fsm u_system_fsm (
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.i_cmd       (i_cmd),
		.i_intl_flag (intl_flag),
		.i_on_step   (on_step),
		.i_off_step  (off_step),
		.o_on_start  (on_start),
		.o_off_start (off_start),
		.o_mc        (o_mc),
		.o_pwm_en    (o_pwm_en),
		.o_fsm_intl  (o_fsm_intl),
		.o_state     (state)
	);

	assign o_status = '{state: state, on_step: on_step, off_step: off_step, faults: faults};

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Builds and runs the testbench with Verilator; the log decides pass or fail.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_mps_top -f all.f -o sim_tb \
	&& ./obj_dir/sim_tb > sim.log 2>&1
grep -q "^Testbench passed$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// File: tb_mps_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mps_top;
	import mps_pkg::*;

	localparam int unsigned STEP_CYCLES    = 8;
	localparam int unsigned CHARGE_TIMEOUT = 32;
	localparam int          NUM_CYCLES     = 20000;
	localparam int          DRAIN_TIMEOUT  = 500;

	logic        i_clk;
	logic        i_rst;
	mps_cmd_t    i_cmd;
	mps_fault_t  i_fault;
	logic        i_intl_clr;
	logic        i_dc_link_ok;
	mps_mc_t     o_mc;
	logic        o_pwm_en;
	logic        o_fsm_intl;
	mps_status_t o_status;

	// Reference model of the latch, both sequencers and the system FSM.
	mps_fault_t    m_faults;
	mps_state_e    m_state;
	logic          m_on_start;
	logic          m_off_start;
	mps_on_step_e  m_on_step;
	mps_off_step_e m_off_step;
	int            m_on_dwell;
	int            m_off_dwell;
	int            m_charge_cnt;
	logic          m_link_seen;
	mps_mc_t       m_mc;

	integer     seed;
	int         link_delay;
	int         link_cnt;
	int         wait_cnt;
	logic [4:0] seen;

	mps_top #(
		.STEP_CYCLES    (STEP_CYCLES),
		.CHARGE_TIMEOUT (CHARGE_TIMEOUT)
	) u_mps_top (
		.i_clk        (i_clk),
		.i_rst        (i_rst),
		.i_cmd        (i_cmd),
		.i_fault      (i_fault),
		.i_intl_clr   (i_intl_clr),
		.i_dc_link_ok (i_dc_link_ok),
		.o_mc         (o_mc),
		.o_pwm_en     (o_pwm_en),
		.o_fsm_intl   (o_fsm_intl),
		.o_status     (o_status)
	);

	initial
	begin
		i_clk = 1'b0;
		forever #5 i_clk = ~i_clk;
	end

	function automatic int rand_below(input int n);
		return $unsigned($random(seed)) % n;
	endfunction

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("Testbench failed");
		$fatal(1);
	endtask

	task automatic check_mc(input mps_mc_t got, input mps_mc_t exp);
		if (got !== exp)
			fail_now($sformatf("** Error at %0t: o_mc is %b, expected %b", $time, got, exp));
	endtask

	task automatic check_state(input mps_state_e got, input logic got_intl, input mps_state_e exp);
		if (got !== exp || got_intl !== (exp == INTL))
			fail_now($sformatf("** Error at %0t: state %s (intl %b), expected %s",
				$time, got.name(), got_intl, exp.name()));
	endtask

	task automatic check_pwm(input logic got, input logic exp);
		if (got !== exp)
			fail_now($sformatf("** Error at %0t: o_pwm_en is %b, expected %b", $time, got, exp));
	endtask

	task automatic check_on_step(input mps_on_step_e got, input mps_on_step_e exp);
		if (got !== exp)
			fail_now($sformatf("** Error at %0t: on-step %s, expected %s",
				$time, got.name(), exp.name()));
	endtask

	task automatic check_off_step(input mps_off_step_e got, input mps_off_step_e exp);
		if (got !== exp)
			fail_now($sformatf("** Error at %0t: off-step %s, expected %s",
				$time, got.name(), exp.name()));
	endtask

	task automatic check_faults(input mps_fault_t got, input mps_fault_t exp);
		if (got !== exp)
			fail_now($sformatf("** Error at %0t: latched faults %b, expected %b",
				$time, got, exp));
	endtask

	// Advances the model by one clock edge from the inputs held over that edge.
	task automatic model_step();
		logic          flag;
		logic          on_done;
		logic          off_done;
		logic          expired;
		mps_state_e    st_n;
		mps_on_step_e  on_n;
		mps_off_step_e off_n;
		mps_mc_t       mc_n;

		flag     = |m_faults;
		on_done  = (m_on_dwell == STEP_CYCLES - 1);
		off_done = (m_off_dwell == STEP_CYCLES - 1);
		expired  = (m_charge_cnt == CHARGE_TIMEOUT - 1);

		st_n = m_state;
		case (m_state)
			IDLE        : if (i_cmd.op_on) st_n = OP_ON;
			OP_ON       : st_n = OP_ON_HOLD;
			OP_ON_HOLD  :
			begin
				if (m_on_step == ON_ABORT)
					st_n = IDLE;
				else if (m_on_step == ON_DONE)
					st_n = READY;
			end
			READY       :
			begin
				if (i_cmd.run)
					st_n = RUN;
				else if (i_cmd.op_off)
					st_n = OP_OFF;
			end
			RUN         : if (i_cmd.ready) st_n = READY;
			OP_OFF      : st_n = OP_OFF_HOLD;
			OP_OFF_HOLD : if (m_off_step == OFF_DONE) st_n = IDLE;
			default     : st_n = IDLE;
		endcase
		if (flag)
			st_n = INTL;

		on_n = m_on_step;
		if (flag)
			on_n = ON_IDLE;
		else if (m_on_step == ON_IDLE && m_on_start)
			on_n = ON_DISCH;
		else if (m_on_step == ON_DISCH && on_done)
			on_n = ON_SLOW;
		else if (m_on_step == ON_SLOW && on_done && (m_link_seen || i_dc_link_ok))
			on_n = ON_MAIN;
		else if (m_on_step == ON_SLOW && expired)
			on_n = ON_ABORT;
		else if (m_on_step == ON_MAIN && on_done)
			on_n = ON_SLOW_OFF;
		else if (m_on_step == ON_SLOW_OFF && on_done)
			on_n = ON_DONE;
		else if (m_on_step == ON_DONE || m_on_step == ON_ABORT)
			on_n = ON_IDLE;

		off_n = m_off_step;
		if (flag || m_off_step == OFF_DONE)
			off_n = OFF_IDLE;
		else if (m_off_step == OFF_IDLE && m_off_start)
			off_n = OFF_MAIN_OPEN;
		else if (m_off_step == OFF_MAIN_OPEN && off_done)
			off_n = OFF_DISCH;
		else if (m_off_step == OFF_DISCH && off_done)
			off_n = OFF_DONE;

		// Contactor bits are discharge_n, slow, main from MSB to LSB.
		mc_n = m_mc;
		if (flag || m_state == INTL)
			mc_n = MC_OPEN;
		else if (m_state == OP_ON_HOLD)
		begin
			case (m_on_step)
				ON_DISCH    : mc_n = mps_mc_t'(3'b100);
				ON_SLOW     : mc_n = mps_mc_t'(3'b110);
				ON_MAIN     : mc_n = mps_mc_t'(3'b111);
				ON_SLOW_OFF : mc_n = mps_mc_t'(3'b101);
				ON_IDLE,
				ON_ABORT    : mc_n = MC_OPEN;
				default     : mc_n = m_mc;
			endcase
		end
		else if (m_state == OP_OFF_HOLD && m_off_step == OFF_MAIN_OPEN)
			mc_n = mps_mc_t'(3'b100);
		else if (m_state == OP_OFF_HOLD && m_off_step == OFF_DISCH)
			mc_n = MC_OPEN;

		if (m_state == OP_ON_HOLD && st_n == READY) seen[0] = 1'b1;
		if (m_state == OP_ON_HOLD && st_n == IDLE) seen[1] = 1'b1;
		if (st_n == RUN) seen[2] = 1'b1;
		if (m_state == OP_OFF_HOLD && st_n == IDLE) seen[3] = 1'b1;
		if (st_n == INTL) seen[4] = 1'b1;

		if (on_n != m_on_step)
			m_on_dwell = 0;
		else if (!on_done)
			m_on_dwell++;
		if (off_n != m_off_step)
			m_off_dwell = 0;
		else if (!off_done)
			m_off_dwell++;
		if (m_on_step != ON_SLOW)
		begin
			m_charge_cnt = 0;
			m_link_seen  = 1'b0;
		end
		else
		begin
			if (!expired)
				m_charge_cnt++;
			if (i_dc_link_ok)
				m_link_seen = 1'b1;
		end

		if (i_intl_clr)
			m_faults = m_faults & i_fault;
		m_faults    = m_faults | i_fault;
		m_on_start  = (m_state == OP_ON);
		m_off_start = (m_state == OP_OFF);
		m_state     = st_n;
		m_on_step   = on_n;
		m_off_step  = off_n;
		m_mc        = mc_n;
	endtask

	// A quiet cycle sends no commands and no faults and keeps clearing the latch.
	task automatic drive_inputs(input logic quiet);
		i_cmd      = '0;
		i_fault    = FAULT_NONE;
		i_intl_clr = quiet;
		if (!quiet)
		begin
			if (rand_below(8) == 0)
				i_cmd = mps_cmd_t'(4'b0001 << rand_below(4));
			if (rand_below(300) == 0)
				i_fault = mps_fault_t'(4'b0001 << rand_below(4));
			if (rand_below(16) == 0)
				i_intl_clr = 1'b1;
		end
		// A new charge delay for each power-on; a negative delay means no charge at all.
		if (m_state == OP_ON)
		begin
			link_cnt   = 0;
			link_delay = (rand_below(4) == 0) ? -1 : rand_below(2 * CHARGE_TIMEOUT);
		end
		if (m_state == IDLE || m_state == INTL)
			i_dc_link_ok = 1'b0;
		else if (link_delay >= 0 && link_cnt >= link_delay)
			i_dc_link_ok = 1'b1;
		link_cnt++;
	endtask

	task automatic run_cycle(input logic quiet);
		@(posedge i_clk);
		model_step();
		#1;
		check_mc(o_mc, m_mc);
		check_state(o_status.state, o_fsm_intl, m_state);
		check_pwm(o_pwm_en, m_state == RUN);
		check_on_step(o_status.on_step, m_on_step);
		check_off_step(o_status.off_step, m_off_step);
		check_faults(o_status.faults, m_faults);
		drive_inputs(quiet);
	endtask

	initial
	begin
		seed         = 10;
		i_rst        = 1'b0;
		i_cmd        = '0;
		i_fault      = FAULT_NONE;
		i_intl_clr   = 1'b0;
		i_dc_link_ok = 1'b0;
		m_faults     = FAULT_NONE;
		m_state      = IDLE;
		m_on_start   = 1'b0;
		m_off_start  = 1'b0;
		m_on_step    = ON_IDLE;
		m_off_step   = OFF_IDLE;
		m_on_dwell   = 0;
		m_off_dwell  = 0;
		m_charge_cnt = 0;
		m_link_seen  = 1'b0;
		m_mc         = MC_OPEN;
		link_delay   = -1;
		link_cnt     = 0;
		seen         = '0;

		repeat (2) @(posedge i_clk);
		#1;
		i_rst = 1'b1;

		for (int i = 0; i < NUM_CYCLES; i++)
			run_cycle(1'b0);

		// Let any sequence in progress finish before the final verdict.
		wait_cnt = 0;
		while (m_state inside {OP_ON, OP_ON_HOLD, OP_OFF, OP_OFF_HOLD, INTL})
		begin
			if (wait_cnt == DRAIN_TIMEOUT)
				fail_now("Timeout: the system never settled in IDLE, READY or RUN");
			run_cycle(1'b1);
			wait_cnt++;
		end

		if (seen != '1)
			fail_now($sformatf("Not every sequence was exercised, seen mask %b", seen));
		else
		begin
			$display("Testbench passed");
			$finish;
		end
	end

endmodule

`default_nettype wire
